/* hw/tlb_array_pkg.sv */
// TLB array shared definitions
package tlb_array_pkg;

   //==========================================================================
   // Array geometry
   //==========================================================================

   localparam int NUM_ENTRIES    = 16;                  // Entries in the array
   localparam int NUM_RD_PORTS   = 2;                   // Independent read ports
   localparam int IDX_W          = $clog2(NUM_ENTRIES); // Entry index width

   // Total output latency in stages, minimum 1
   // Stage 1 lives in the store, the rest in the output pipes
   localparam int NUM_PIPE_STAGE = 2;

   //==========================================================================
   // Entry layout
   //==========================================================================

   localparam int TAG_W          = 20;                  // Search tag, low bits of an entry
   localparam int ENTRY_W        = 32;                  // Full stored entry

   // Index of one entry, used by both read ports and the write port
   typedef logic [IDX_W-1:0]       tlb_idx_t;

   // Tag compared by the CAM search
   typedef logic [TAG_W-1:0]       tlb_tag_t;

   // Stored entry
   // Bits [TAG_W-1:0] hold the tag, upper bits are opaque payload
   typedef logic [ENTRY_W-1:0]     tlb_entry_t;

   // One hit bit per entry, bit i set for a match on entry i
   typedef logic [NUM_ENTRIES-1:0] tlb_hit_t;

endpackage

/* hw/tlb_array_top.sv */
// TLB storage array top
`timescale 1ns/1ns

module tlb_array_top (
   input  logic                                   clk,
   input  logic                                   reset,

   // CAM search
   input  logic                                   cam_en,
   input  tlb_array_pkg::tlb_tag_t                cam_data,
   output tlb_array_pkg::tlb_hit_t                cam_hit,

   // Reads
   input  logic [tlb_array_pkg::NUM_RD_PORTS-1:0] rd_en,
   input  tlb_array_pkg::tlb_idx_t                rd_addr [tlb_array_pkg::NUM_RD_PORTS],
   output tlb_array_pkg::tlb_entry_t              rd_data [tlb_array_pkg::NUM_RD_PORTS],

   // Write
   input  logic                                   wr_en,
   input  tlb_array_pkg::tlb_idx_t                wr_addr,
   input  tlb_array_pkg::tlb_entry_t              wr_data
);

   import tlb_array_pkg::*;

   tlb_hit_t                 hit1;                     // Stage 1 hit vector
   logic                     cam_vld1;                 // Stage 1 search enable
   tlb_entry_t               rd_data1 [NUM_RD_PORTS];  // Stage 1 read data
   logic [NUM_RD_PORTS-1:0]  rd_vld1;                  // Stage 1 read enables

   genvar g_port;

   tlb_entry_store u_store (
      .clk      (clk),
      .reset    (reset),
      .cam_en   (cam_en),
      .cam_data (cam_data),
      .rd_en    (rd_en),
      .rd_addr  (rd_addr),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data),
      .hit1     (hit1),
      .cam_vld1 (cam_vld1),
      .rd_data1 (rd_data1),
      .rd_vld1  (rd_vld1)
   );

   // Hit vector stream
   tlb_stage_pipe #(.WIDTH(NUM_ENTRIES)) u_cam_pipe (
      .clk      (clk),
      .reset    (reset),
      .in_vld   (cam_vld1),
      .in_data  (hit1),
      .out_data (cam_hit)
   );

   // One data stream per read port
   for (g_port = 0; g_port < NUM_RD_PORTS; g_port++) begin : gen_rd_pipe
      tlb_stage_pipe #(.WIDTH(ENTRY_W)) u_rd_pipe (
         .clk      (clk),
         .reset    (reset),
         .in_vld   (rd_vld1[g_port]),
         .in_data  (rd_data1[g_port]),
         .out_data (rd_data[g_port])
      );
   end

endmodule

/* hw/tlb_entry_store.sv */
// TLB entry storage and stage 1
`timescale 1ns/1ns

module tlb_entry_store (
   input  logic                                   clk,
   input  logic                                   reset,

   // CAM search
   input  logic                                   cam_en,
   input  tlb_array_pkg::tlb_tag_t                cam_data,

   // Reads, one address per port
   input  logic [tlb_array_pkg::NUM_RD_PORTS-1:0] rd_en,
   input  tlb_array_pkg::tlb_idx_t                rd_addr [tlb_array_pkg::NUM_RD_PORTS],

   // Write
   input  logic                                   wr_en,
   input  tlb_array_pkg::tlb_idx_t                wr_addr,
   input  tlb_array_pkg::tlb_entry_t              wr_data,

   // Stage 1 results with their staged enables
   output tlb_array_pkg::tlb_hit_t                hit1,
   output logic                                   cam_vld1,
   output tlb_array_pkg::tlb_entry_t              rd_data1 [tlb_array_pkg::NUM_RD_PORTS],
   output logic [tlb_array_pkg::NUM_RD_PORTS-1:0] rd_vld1
);

   import tlb_array_pkg::*;

   //==========================================================================
   // Storage
   //==========================================================================

   tlb_entry_t entry_q [NUM_ENTRIES];        // Entry flops
   tlb_hit_t   valid_q;                      // One valid bit per entry

   tlb_hit_t   hit_nxt;                      // Raw compare result, pre-flop
   tlb_entry_t rd_nxt  [NUM_RD_PORTS];       // Muxed read data, pre-flop

   genvar g_port;

   // Write lands at the edge, so same-cycle reads see the old entry
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < NUM_ENTRIES; i++) begin
            entry_q[i] <= '0;
         end
         valid_q <= '0;                      // Nothing valid out of reset
      end else if (wr_en) begin
         entry_q[wr_addr] <= wr_data;        // Whole entry replaced
         valid_q[wr_addr] <= 1'b1;
      end
   end

   //==========================================================================
   // Tag compare and read muxes
   //==========================================================================

   // Hit needs a valid entry and an exact tag match
   always_comb begin
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         hit_nxt[i] = valid_q[i] && (entry_q[i][TAG_W-1:0] == cam_data);
      end
   end

   always_comb begin
      for (int p = 0; p < NUM_RD_PORTS; p++) begin
         rd_nxt[p] = entry_q[rd_addr[p]];    // Plain binary decode
      end
   end

   //==========================================================================
   // Stage 1 registers
   //==========================================================================

   // Hit vector loads only on a search, otherwise holds
   always_ff @(posedge clk) begin
      if (reset) begin
         hit1     <= '0;
         cam_vld1 <= 1'b0;
      end else begin
         cam_vld1 <= cam_en;                 // Enable rides along with the data
         if (cam_en) begin
            hit1 <= hit_nxt;
         end
      end
   end

   for (g_port = 0; g_port < NUM_RD_PORTS; g_port++) begin : gen_rd_port
      always_ff @(posedge clk) begin
         if (reset) begin
            rd_data1[g_port] <= '0;
            rd_vld1[g_port]  <= 1'b0;
         end else begin
            rd_vld1[g_port] <= rd_en[g_port];
            if (rd_en[g_port]) begin
               rd_data1[g_port] <= rd_nxt[g_port];   // Only on a real read
            end
         end
      end

      // Read of the index being written would return stale data
      a_rd_wr_conflict: assert property (@(posedge clk) disable iff (reset)
         !(rd_en[g_port] && wr_en && (rd_addr[g_port] == wr_addr)))
         else $error("read and write to index %0d in the same cycle", wr_addr);
   end

   // Enables must be known once reset is released
   a_en_known: assert property (@(posedge clk) disable iff (reset)
      !$isunknown({cam_en, rd_en, wr_en}))
      else $error("unknown enable on the array inputs");

endmodule

/* hw/tlb_stage_pipe.sv */
// Enable-staged output pipe
`timescale 1ns/1ns

module tlb_stage_pipe #(
   parameter int WIDTH = 32                  // Payload width of the stream
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             in_vld,          // Stage 1 enable from the store
   input  logic [WIDTH-1:0] in_data,         // Stage 1 payload
   output logic [WIDTH-1:0] out_data         // Payload of the last stage
);

   import tlb_array_pkg::*;

   genvar g_stage;

   //==========================================================================
   // Stages 2 .. NUM_PIPE_STAGE
   //==========================================================================

   if (NUM_PIPE_STAGE > 1) begin : gen_stages
      // Index 0 is the store's stage 1, index s is stage s+1
      // The last stage needs no enable since nothing follows it
      logic             stg_vld  [NUM_PIPE_STAGE-1];
      logic [WIDTH-1:0] stg_data [NUM_PIPE_STAGE];

      assign stg_vld[0]  = in_vld;
      assign stg_data[0] = in_data;

      for (g_stage = 1; g_stage < NUM_PIPE_STAGE; g_stage++) begin : gen_stage
         // Loads only when the previous stage holds an item
         always_ff @(posedge clk) begin
            if (reset) begin
               stg_data[g_stage] <= '0;
            end else if (stg_vld[g_stage-1]) begin
               stg_data[g_stage] <= stg_data[g_stage-1];
            end
         end

         if (g_stage < NUM_PIPE_STAGE-1) begin : gen_vld
            always_ff @(posedge clk) begin
               if (reset) begin
                  stg_vld[g_stage] <= 1'b0;
               end else begin
                  stg_vld[g_stage] <= stg_vld[g_stage-1];   // One cycle behind
               end
            end
         end

         // Stage holds its item until the next one arrives
         a_stage_hold: assert property (@(posedge clk) disable iff (reset)
            !stg_vld[g_stage-1] |=> $stable(stg_data[g_stage]))
            else $error("stage %0d changed without an enable", g_stage + 1);
      end

      assign out_data = stg_data[NUM_PIPE_STAGE-1];
   end else begin : gen_bypass
      assign out_data = in_data;             // Single stage, store output is final
   end

endmodule

/* project.f */
+incdir+include
hw/tlb_array_pkg.sv
hw/tlb_entry_store.sv
hw/tlb_stage_pipe.sv
hw/tlb_array_top.sv
sim/tlb_array_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the TLB array testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   -f project.f --top-module tlb_array_tb -o tlb_array_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/tlb_array_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "test passed"; then
   echo "RESULT: PASS"
   exit 0
fi

echo "RESULT: FAIL"
exit 1

/* include/tlb_array_model.svh */
// TLB array reference model
`ifndef TLB_ARRAY_MODEL_SVH
`define TLB_ARRAY_MODEL_SVH

tlb_array_pkg::tlb_entry_t exp_entries [tlb_array_pkg::NUM_ENTRIES];    // Expected contents
tlb_array_pkg::tlb_hit_t   exp_valid;                                    // Expected valid bits
tlb_array_pkg::tlb_hit_t   exp_hit_q [$];                                // Pending search results
tlb_array_pkg::tlb_entry_t exp_rd_q  [tlb_array_pkg::NUM_RD_PORTS][$];  // Pending reads per port

// Matches the array right after reset
function automatic void reset_model();
   for (int i = 0; i < tlb_array_pkg::NUM_ENTRIES; i++) begin
      exp_entries[i] = '0;
   end
   exp_valid = '0;
   exp_hit_q.delete();
   for (int p = 0; p < tlb_array_pkg::NUM_RD_PORTS; p++) begin
      exp_rd_q[p].delete();
   end
endfunction

function automatic tlb_array_pkg::tlb_hit_t expected_hits(tlb_array_pkg::tlb_tag_t tag);
   tlb_array_pkg::tlb_hit_t hit;
   hit = '0;
   for (int i = 0; i < tlb_array_pkg::NUM_ENTRIES; i++) begin
      hit[i] = exp_valid[i] && (exp_entries[i][tlb_array_pkg::TAG_W-1:0] == tag);
   end
   return hit;
endfunction

// Launch calls come before write_entry() in a cycle, so they see old contents
function automatic void launch_search(tlb_array_pkg::tlb_tag_t tag);
   exp_hit_q.push_back(expected_hits(tag));
endfunction

function automatic void launch_read(int port, tlb_array_pkg::tlb_idx_t idx);
   exp_rd_q[port].push_back(exp_entries[idx]);
endfunction

function automatic void write_entry(tlb_array_pkg::tlb_idx_t idx,
                                    tlb_array_pkg::tlb_entry_t data);
   exp_entries[idx] = data;
   exp_valid[idx]   = 1'b1;
endfunction

`endif

/* sim/tlb_array_tb.sv */
// TLB array testbench
`timescale 1ns/1ns

module tlb_array_tb;

   import tlb_array_pkg::*;

   `include "tlb_array_model.svh"

   localparam int DRAIN_LIMIT = 20;             // Idle cycles allowed for results to drain

   logic                    clk;
   logic                    reset;
   logic                    cam_en;
   tlb_tag_t                cam_data;
   tlb_hit_t                cam_hit;
   logic [NUM_RD_PORTS-1:0] rd_en;
   tlb_idx_t                rd_addr [NUM_RD_PORTS];
   tlb_entry_t              rd_data [NUM_RD_PORTS];
   logic                    wr_en;
   tlb_idx_t                wr_addr;
   tlb_entry_t              wr_data;

   // Operation that the next run_cycle call applies
   logic                    op_cam_en;
   tlb_tag_t                op_cam_tag;
   logic [NUM_RD_PORTS-1:0] op_rd_en;
   tlb_idx_t                op_rd_addr [NUM_RD_PORTS];
   logic                    op_wr_en;
   tlb_idx_t                op_wr_addr;
   tlb_entry_t              op_wr_data;

   int         cycle = 0;                       // Rising edges seen so far
   int         hit_due_q [$];                   // Output cycle of each pending search
   int         rd_due_q  [NUM_RD_PORTS][$];     // Output cycle of each pending read
   tlb_hit_t   last_hit;                        // Value the hit output holds now
   tlb_entry_t last_rd   [NUM_RD_PORTS];
   int         checks = 0;
   int         errors = 0;
   int         test_checks = 0;                 // Counts at the start of the current test
   int         test_errors = 0;
   int         seed_ret;

   tlb_array_top u_dut (
      .clk      (clk),
      .reset    (reset),
      .cam_en   (cam_en),
      .cam_data (cam_data),
      .cam_hit  (cam_hit),
      .rd_en    (rd_en),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;                    // 4 ns period
   end

   always @(posedge clk) cycle <= cycle + 1;

   //==========================================================================
   // Helpers
   //==========================================================================

   task automatic compare_values(string name, logic [31:0] actual, logic [31:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("MISMATCH %s: got 0x%08h, expected 0x%08h at %0t", name, actual, expected,
                  $time);
      end
   endtask

   task automatic clear_ops();
      op_cam_en  = 1'b0;
      op_cam_tag = '0;
      op_rd_en   = '0;
      op_wr_en   = 1'b0;
      op_wr_addr = '0;
      op_wr_data = '0;
      for (int p = 0; p < NUM_RD_PORTS; p++) begin
         op_rd_addr[p] = '0;
      end
   endtask

   function automatic tlb_idx_t rand_idx();
      return tlb_idx_t'($urandom_range(NUM_ENTRIES-1, 0));
   endfunction

   // Random index that differs from avoid
   function automatic tlb_idx_t other_idx(tlb_idx_t avoid);
      tlb_idx_t idx;
      idx = rand_idx();
      if (idx == avoid) begin
         idx = idx + tlb_idx_t'(1);              // Wraps within the array
      end
      return idx;
   endfunction

   function automatic bit results_pending();
      bit busy;
      busy = (hit_due_q.size() != 0);
      for (int p = 0; p < NUM_RD_PORTS; p++) begin
         busy = busy || (rd_due_q[p].size() != 0);
      end
      return busy;
   endfunction

   // Releases results that are due this cycle, then checks every output
   task automatic check_outputs();
      if (hit_due_q.size() != 0 && hit_due_q[0] == cycle) begin
         void'(hit_due_q.pop_front());
         last_hit = exp_hit_q.pop_front();
      end
      compare_values("cam_hit", 32'(cam_hit), 32'(last_hit));
      for (int p = 0; p < NUM_RD_PORTS; p++) begin
         if (rd_due_q[p].size() != 0 && rd_due_q[p][0] == cycle) begin
            void'(rd_due_q[p].pop_front());
            last_rd[p] = exp_rd_q[p].pop_front();
         end
         compare_values($sformatf("rd_data[%0d]", p), rd_data[p], last_rd[p]);
      end
   endtask

   // Called at a falling edge, returns at the next one
   task automatic run_cycle();
      int due;
      check_outputs();
      due      = cycle + NUM_PIPE_STAGE;        // Launch edge is cycle+1
      cam_en   = op_cam_en;
      cam_data = op_cam_tag;
      rd_en    = op_rd_en;
      wr_en    = op_wr_en;
      wr_addr  = op_wr_addr;
      wr_data  = op_wr_data;
      if (op_cam_en) begin
         launch_search(op_cam_tag);
         hit_due_q.push_back(due);
      end
      for (int p = 0; p < NUM_RD_PORTS; p++) begin
         rd_addr[p] = op_rd_addr[p];
         if (op_rd_en[p]) begin
            launch_read(p, op_rd_addr[p]);
            rd_due_q[p].push_back(due);
         end
      end
      if (op_wr_en) begin
         write_entry(op_wr_addr, op_wr_data);   // After launches, reads see old data
      end
      @(negedge clk);
   endtask

   task automatic drain_results();
      int waited;
      waited = 0;
      clear_ops();
      while (results_pending() && waited < DRAIN_LIMIT) begin
         run_cycle();
         waited++;
      end
      if (results_pending()) begin
         errors++;
         $display("Timeout: results still pending after %0d idle cycles", waited);
      end
      run_cycle();                              // Outputs must hold while idle
      run_cycle();
   endtask

   task automatic finish_test(string name);
      $display("%s: %0d checks, %0d errors", name, checks - test_checks,
               errors - test_errors);
      test_checks = checks;
      test_errors = errors;
   endtask

   //==========================================================================
   // Test sequence
   //==========================================================================

   initial begin
      tlb_idx_t dup_src;
      seed_ret = $urandom(32'haf05);
      reset_model();
      reset    = 1'b1;
      cam_en   = 1'b0;
      cam_data = '0;
      rd_en    = '0;
      wr_en    = 1'b0;
      wr_addr  = '0;
      wr_data  = '0;
      last_hit = '0;
      for (int p = 0; p < NUM_RD_PORTS; p++) begin
         rd_addr[p] = '0;
         last_rd[p] = '0;
      end
      clear_ops();
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // Outputs start at zero and tag 0 misses with no entry valid
      op_cam_en = 1'b1;
      run_cycle();
      drain_results();
      finish_test("reset_state");

      for (int i = 0; i < NUM_ENTRIES; i++) begin
         clear_ops();
         op_wr_en   = 1'b1;
         op_wr_addr = tlb_idx_t'(i);
         op_wr_data = tlb_entry_t'($urandom);
         run_cycle();
      end
      for (int n = 0; n < 24; n++) begin
         clear_ops();
         op_rd_en = '1;
         for (int p = 0; p < NUM_RD_PORTS; p++) begin
            op_rd_addr[p] = rand_idx();
         end
         run_cycle();
         clear_ops();
         run_cycle();                           // Gap keeps each read on its own
      end
      drain_results();
      finish_test("write_then_read");

      // Copy tags between entries to get multiple hits
      for (int n = 0; n < 4; n++) begin
         clear_ops();
         op_wr_en   = 1'b1;
         op_wr_addr = rand_idx();
         dup_src    = other_idx(op_wr_addr);
         op_wr_data = tlb_entry_t'($urandom);
         op_wr_data[TAG_W-1:0] = exp_entries[dup_src][TAG_W-1:0];
         run_cycle();
      end
      for (int i = 0; i < NUM_ENTRIES + 8; i++) begin
         clear_ops();
         op_cam_en  = 1'b1;
         op_cam_tag = (i < NUM_ENTRIES) ? exp_entries[i][TAG_W-1:0] : tlb_tag_t'($urandom);
         run_cycle();
      end
      drain_results();
      finish_test("tag_search");

      for (int n = 0; n < 40; n++) begin
         clear_ops();
         op_cam_en  = ($urandom_range(3, 0) != 0);
         op_cam_tag = ($urandom_range(1, 0) != 0) ? exp_entries[rand_idx()][TAG_W-1:0]
                                                 : tlb_tag_t'($urandom);
         for (int p = 0; p < NUM_RD_PORTS; p++) begin
            op_rd_en[p]   = ($urandom_range(3, 0) != 0);
            op_rd_addr[p] = rand_idx();
         end
         run_cycle();
      end
      drain_results();
      for (int n = 0; n < 6; n++) begin
         run_cycle();                           // Last results stay put
      end
      finish_test("back_to_back");

      // Write tag is searched in its own cycle, so the new entry must miss
      for (int n = 0; n < 32; n++) begin
         clear_ops();
         op_wr_en   = 1'b1;
         op_wr_addr = rand_idx();
         op_wr_data = tlb_entry_t'($urandom);
         op_rd_en   = '1;
         for (int p = 0; p < NUM_RD_PORTS; p++) begin
            op_rd_addr[p] = other_idx(op_wr_addr);
         end
         op_cam_en  = 1'b1;
         op_cam_tag = op_wr_data[TAG_W-1:0];
         run_cycle();
      end
      drain_results();
      finish_test("write_read_same_cycle");

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule
